//--- dv/branchClusterChecker.sv
`timescale 1ns/1ns

module branchClusterChecker (
    input  logic        clk,
    input  logic        rst,
    input  logic        dispatchValid,
    input  logic        dispatchReady,
    input  brPkg::instT inst,
    input  brPkg::addrT pc,
    input  logic        pred,
    input  brPkg::dataT operandA,
    input  brPkg::dataT operandB,
    input  brPkg::tagT  tagA,
    input  brPkg::tagT  tagB,
    input  logic        aluValid,
    input  brPkg::tagT  aluTag,
    input  brPkg::dataT aluData,
    input  logic        lsValid,
    input  brPkg::tagT  lsTag,
    input  brPkg::dataT lsData,
    input  logic        resolveValid,
    input  brPkg::addrT resolvePc,
    input  logic        resolveTaken,
    input  brPkg::addrT resolveTarget,
    input  logic        mispredict,
    input  brPkg::addrT redirectPc,
    output int          outstanding,
    output int          errorCount,
    output int          resolvedCount
);

    typedef struct packed {
        logic        taken;
        brPkg::addrT target;
        brPkg::addrT redirect;
        logic        mispredict;
    } resultT;

    // expected branches in dispatch order, operands filled in as broadcasts arrive
    brPkg::instT qInst [$];
    brPkg::addrT qPc [$];
    bit          qPred [$];
    brPkg::dataT qA [$];
    brPkg::dataT qB [$];
    brPkg::tagT  qTagA [$];
    brPkg::tagT  qTagB [$];
    bit          qIdle [$];
    int          qEdge [$];
    int          sampleIdx = 0;
    int          pendingCount = 0;
    int          errCount = 0;
    int          resolved = 0;

    assign outstanding   = pendingCount;
    assign errorCount    = errCount;
    assign resolvedCount = resolved;

    function automatic resultT predictResolve(input brPkg::instT word, input brPkg::addrT addr,
                                              input brPkg::dataT a, input brPkg::dataT b,
                                              input logic p);
        resultT      r;
        brPkg::dataT offset;
        // B-type offset is imm[12|10:5] in bits 31:25 and imm[4:1|11] in bits 11:7
        offset = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        case (word[14:12])
            3'b000:  r.taken = (a == b);
            3'b001:  r.taken = (a != b);
            3'b100:  r.taken = ($signed(a) < $signed(b));
            3'b101:  r.taken = ($signed(a) >= $signed(b));
            3'b110:  r.taken = (a < b);
            3'b111:  r.taken = (a >= b);
            default: r.taken = 1'b0;
        endcase
        r.target     = addr + offset;
        r.redirect   = r.taken ? r.target : addr + 32'd4;
        r.mispredict = (r.taken != p);
        return r;
    endfunction

    task automatic compareField(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
        if (gotVal !== expVal) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expVal, gotVal);
            errCount++;
        end
    endtask

    task automatic dropHead();
        void'(qInst.pop_front());
        void'(qPc.pop_front());
        void'(qPred.pop_front());
        void'(qA.pop_front());
        void'(qB.pop_front());
        void'(qTagA.pop_front());
        void'(qTagB.pop_front());
        void'(qIdle.pop_front());
        void'(qEdge.pop_front());
    endtask

    task automatic dropAll();
        while (qInst.size() != 0) begin
            dropHead();
        end
    endtask

    task automatic checkResolve();
        resultT expRes;
        if (mispredict && !resolveValid) begin
            $display("error at %0t ns: mispredict raised without resolveValid", $time);
            errCount++;
        end
        if (resolveValid && qInst.size() == 0) begin
            $display("error at %0t ns: resolveValid high with no branch outstanding", $time);
            errCount++;
        end else if (resolveValid) begin
            if (qTagA[0] != brPkg::tagFree || qTagB[0] != brPkg::tagFree) begin
                $display("error at %0t ns: branch at pc %h resolved before its operands arrived",
                         $time, qPc[0]);
                errCount++;
            end
            expRes = predictResolve(qInst[0], qPc[0], qA[0], qB[0], qPred[0]);
            compareField("resolvePc", qPc[0], resolvePc);
            compareField("resolveTaken", 32'(expRes.taken), 32'(resolveTaken));
            compareField("resolveTarget", expRes.target, resolveTarget);
            compareField("mispredict", 32'(expRes.mispredict), 32'(mispredict));
            compareField("redirectPc", expRes.redirect, redirectPc);
            if (qIdle[0]) begin
                compareField("resolveLatency", 32'd4, 32'(sampleIdx - qEdge[0]));
            end
            resolved++;
            dropHead();
            // every branch still expected is younger and gets flushed
            if (expRes.mispredict) begin
                dropAll();
            end
        end
    endtask

    task automatic applyBroadcast(input logic valid, input brPkg::tagT tag,
                                  input brPkg::dataT data);
        if (valid && tag != brPkg::tagFree) begin
            foreach (qTagA[i]) begin
                if (qTagA[i] == tag) begin
                    qA[i]    = data;
                    qTagA[i] = brPkg::tagFree;
                end
                if (qTagB[i] == tag) begin
                    qB[i]    = data;
                    qTagB[i] = brPkg::tagFree;
                end
            end
        end
    endtask

    // sampled mid-cycle, so a dispatch seen here is accepted at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            sampleIdx++;
            checkResolve();
            applyBroadcast(aluValid, aluTag, aluData);
            applyBroadcast(lsValid, lsTag, lsData);
            if (dispatchValid && dispatchReady) begin
                qIdle.push_back(qInst.size() == 0 && tagA == brPkg::tagFree &&
                                tagB == brPkg::tagFree);
                qInst.push_back(inst);
                qPc.push_back(pc);
                qPred.push_back(pred);
                qA.push_back(operandA);
                qB.push_back(operandB);
                qTagA.push_back(tagA);
                qTagB.push_back(tagB);
                qEdge.push_back(sampleIdx + 1);
            end
            pendingCount = qInst.size();
        end
    end

endmodule

//--- dv/branchClusterTb.sv
`timescale 1ns/1ns

module branchClusterTb;

    localparam int clkPeriod     = 20;
    localparam int directedCount = 32;
    localparam int batchCount    = 20;
    localparam int batchMax      = 7;
    localparam int fullCount     = 7;
    localparam int totalBranches = directedCount + batchCount * batchMax + fullCount;

    logic        clk;
    logic        rst;
    logic        dispatchValid;
    logic        dispatchReady;
    brPkg::instT inst;
    brPkg::addrT pc;
    logic        pred;
    brPkg::dataT operandA;
    brPkg::dataT operandB;
    brPkg::tagT  tagA;
    brPkg::tagT  tagB;
    logic        aluValid;
    brPkg::tagT  aluTag;
    brPkg::dataT aluData;
    logic        lsValid;
    brPkg::tagT  lsTag;
    brPkg::dataT lsData;
    logic        resolveValid;
    brPkg::addrT resolvePc;
    logic        resolveTaken;
    brPkg::addrT resolveTarget;
    logic        mispredict;
    brPkg::addrT redirectPc;
    int          outstanding;
    int          errorCount;
    int          resolvedCount;
    int          cycle = 0;
    int          stallCycles = 0;
    int          tbErrors = 0;

    // broadcasts waiting for their cycle, bcBus set means the load/store bus
    brPkg::tagT  bcTag [$];
    brPkg::dataT bcData [$];
    bit          bcBus [$];
    int          bcAt [$];

    branchCluster i_dut (.*);

    branchClusterChecker i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic queueBroadcast(input brPkg::tagT t, input brPkg::dataT v, input int at);
        bcTag.push_back(t);
        bcData.push_back(v);
        bcBus.push_back(1'($urandom));
        bcAt.push_back(at);
    endtask

    task automatic driveBroadcasts();
        bit aluBusy;
        bit lsBusy;
        int i;
        aluBusy  = 1'b0;
        lsBusy   = 1'b0;
        aluValid = 1'b0;
        lsValid  = 1'b0;
        i        = 0;
        while (i < bcTag.size()) begin
            if (bcAt[i] <= cycle && !(bcBus[i] ? lsBusy : aluBusy)) begin
                if (bcBus[i]) begin
                    lsValid = 1'b1;
                    lsTag   = bcTag[i];
                    lsData  = bcData[i];
                    lsBusy  = 1'b1;
                end else begin
                    aluValid = 1'b1;
                    aluTag   = bcTag[i];
                    aluData  = bcData[i];
                    aluBusy  = 1'b1;
                end
                bcTag.delete(i);
                bcData.delete(i);
                bcBus.delete(i);
                bcAt.delete(i);
            end else begin
                i++;
            end
        end
    endtask

    always @(posedge clk) begin
        #2;
        driveBroadcasts();
    end

    function automatic brPkg::instT makeBranchWord(input logic [2:0] funct3,
                                                   input logic [12:0] offset);
        logic [4:0] rs1;
        logic [4:0] rs2;
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11], 7'b1100011};
    endfunction

    // the broadcast of a waiting tag never lands before the allocation cycle
    task automatic dispatchBranch(input brPkg::instT word, input brPkg::addrT addr,
                                  input logic p, input brPkg::dataT a, input brPkg::dataT b,
                                  input brPkg::tagT ta, input brPkg::tagT tb,
                                  input brPkg::dataT valA, input brPkg::dataT valB,
                                  input int delay);
        dispatchValid = 1'b1;
        inst          = word;
        pc            = addr;
        pred          = p;
        operandA      = a;
        operandB      = b;
        tagA          = ta;
        tagB          = tb;
        @(negedge clk);
        while (!dispatchReady) begin
            stallCycles++;
            @(negedge clk);
        end
        if (ta != brPkg::tagFree) begin
            queueBroadcast(ta, valA, cycle + 1 + delay);
        end
        if (tb != brPkg::tagFree) begin
            queueBroadcast(tb, valB, cycle + 1 + delay + $urandom_range(0, 2));
        end
        @(posedge clk);
        #2;
        dispatchValid = 1'b0;
    endtask

    task automatic sendRandomBranch(inout int nextTag);
        brPkg::dataT a;
        brPkg::dataT b;
        brPkg::dataT valA;
        brPkg::tagT  ta;
        brPkg::tagT  tb;
        a    = $urandom;
        b    = ($urandom_range(0, 3) == 0) ? a : $urandom;
        valA = ($urandom_range(0, 3) == 0) ? b : $urandom;
        ta   = brPkg::tagFree;
        tb   = brPkg::tagFree;
        if ($urandom_range(0, 2) == 0) begin
            ta = brPkg::tagT'(nextTag);
            nextTag++;
        end
        if ($urandom_range(0, 2) == 0) begin
            tb = brPkg::tagT'(nextTag);
            nextTag++;
        end
        dispatchBranch(makeBranchWord(3'($urandom), 13'($urandom)), $urandom & ~32'h3,
                       1'($urandom), a, b, ta, tb, valA, $urandom, $urandom_range(0, 6));
    endtask

    task automatic waitIdle();
        @(posedge clk);
        while (outstanding != 0 || bcTag.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #2;
    endtask

    initial begin
        brPkg::dataT edgeA [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h0000_0005, 32'h0000_0000};
        brPkg::dataT edgeB [4] = '{32'h7fff_ffff, 32'h0000_0000, 32'h0000_0005, 32'h8000_0000};
        brPkg::dataT fillB;
        int          nextTag;
        int          stallBefore;
        void'($urandom(13728));
        rst           = 1'b1;
        dispatchValid = 1'b0;
        inst          = '0;
        pc            = '0;
        pred          = 1'b0;
        operandA      = '0;
        operandB      = '0;
        tagA          = brPkg::tagFree;
        tagB          = brPkg::tagFree;
        aluValid      = 1'b0;
        aluTag        = brPkg::tagFree;
        aluData       = '0;
        lsValid       = 1'b0;
        lsTag         = brPkg::tagFree;
        lsData        = '0;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // signed and unsigned extremes against every funct3, each into an idle cluster
        for (int p = 0; p < 4; p++) begin
            for (int f = 0; f < 8; f++) begin
                dispatchBranch(makeBranchWord(3'(f), 13'($urandom)), $urandom & ~32'h3,
                               1'($urandom), edgeA[p], edgeB[p], brPkg::tagFree,
                               brPkg::tagFree, '0, '0, 0);
                waitIdle();
            end
        end

        for (int n = 0; n < batchCount; n++) begin
            nextTag = 1;
            repeat ($urandom_range(1, batchMax)) sendRandomBranch(nextTag);
            waitIdle();
        end

        // late broadcasts keep the head waiting until the queue is full
        stallBefore = stallCycles;
        for (int k = 0; k < fullCount; k++) begin
            fillB = $urandom;
            dispatchBranch(makeBranchWord(3'b000, 13'($urandom)), $urandom & ~32'h3, 1'b1,
                           32'hdead_0000 + k, fillB, brPkg::tagT'(k + 1), brPkg::tagFree,
                           fillB, '0, 15);
        end
        waitIdle();
        if (stallCycles == stallBefore) begin
            $display("error at %0t ns: dispatchReady never dropped while the queue was full",
                     $time);
            tbErrors++;
        end

        $display("resolved %0d branches, %0d checker errors, %0d testbench errors, %0d assertion failures",
                 resolvedCount, errorCount, tbErrors, i_dut.i_props.failCount);
        if (errorCount == 0 && tbErrors == 0 && i_dut.i_props.failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(totalBranches * 40 * clkPeriod);
        $display("error at %0t ns: watchdog expired before all branches resolved", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- dv/branchCluster_props.sv
`timescale 1ns/1ns

module branchClusterProps (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic resolveValid,
    input logic dispatchReady
);

    int failCount = 0;

    // the result stage discards whatever reaches it during its own flush
    quietAfterFlush: assert property (@(posedge clk) disable iff (rst) flush |=> !resolveValid)
        else begin
            $error("resolveValid high directly after a flush");
            failCount++;
        end

    flushBlocksDispatch: assert property (@(posedge clk) disable iff (rst) flush |-> !dispatchReady)
        else begin
            $error("dispatchReady high during a flush");
            failCount++;
        end

endmodule

bind branchCluster branchClusterProps i_props (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .resolveValid  (resolveValid),
    .dispatchReady (dispatchReady)
);

//--- project.f
verilog/brPkg.sv
verilog/brIfs.sv
verilog/branchDecode.sv
verilog/branchRsLine.sv
verilog/branchRs.sv
verilog/branchExecute.sv
verilog/branchResult.sv
verilog/branchCluster.sv
dv/branchCluster_props.sv
dv/branchClusterChecker.sv
dv/branchClusterTb.sv

//--- verilog/brIfs.sv
`timescale 1ns/1ns

// result buses from the ALU and the load/store unit
interface wakeupIf;
    logic        aluValid;
    brPkg::tagT  aluTag;
    brPkg::dataT aluData;
    logic        lsValid;
    brPkg::tagT  lsTag;
    brPkg::dataT lsData;

    modport sink (input aluValid, aluTag, aluData, lsValid, lsTag, lsData);
endinterface

// decoded branch on its way into the reservation queue
interface allocIf;
    logic        valid;
    brPkg::brOpT op;
    brPkg::dataT operandA;
    brPkg::dataT operandB;
    brPkg::tagT  tagA;
    brPkg::tagT  tagB;
    brPkg::dataT imm;
    brPkg::addrT pc;
    logic        pred;

    modport source (output valid, op, operandA, operandB, tagA, tagB, imm, pc, pred);
    modport sink (input valid, op, operandA, operandB, tagA, tagB, imm, pc, pred);
endinterface

interface issueIf;
    logic        valid;
    brPkg::brOpT op;
    brPkg::dataT operandA;
    brPkg::dataT operandB;
    brPkg::dataT imm;
    brPkg::addrT pc;
    logic        pred;

    modport source (output valid, op, operandA, operandB, imm, pc, pred);
    modport sink (input valid, op, operandA, operandB, imm, pc, pred);
endinterface

interface resolveIf;
    logic        valid;
    brPkg::addrT pc;
    logic        taken;
    brPkg::addrT target;
    logic        pred;

    modport source (output valid, pc, taken, target, pred);
    modport sink (input valid, pc, taken, target, pred);
endinterface

//--- verilog/brPkg.sv
package brPkg;

    // one machine word for operands and results
    typedef logic [31:0] dataT;

    typedef logic [31:0] addrT;

    typedef logic [31:0] instT;

    // rename tag, zero means the operand value is already present
    typedef logic [3:0] tagT;

    localparam tagT tagFree = 4'd0;

    // branch op is the raw funct3 field
    typedef logic [2:0] brOpT;

    localparam brOpT opBeq  = 3'b000;
    localparam brOpT opBne  = 3'b001;
    localparam brOpT opBlt  = 3'b100;
    localparam brOpT opBge  = 3'b101;
    localparam brOpT opBltu = 3'b110;
    localparam brOpT opBgeu = 3'b111;

    // reservation queue depth, a power of two so the slot index wraps by itself
    localparam int rsSize = 4;

    typedef logic [1:0] slotT;

endpackage

//--- verilog/branchCluster.sv
`timescale 1ns/1ns

module branchCluster (
    input  logic        clk,
    input  logic        rst,
    input  logic        dispatchValid,
    output logic        dispatchReady,
    input  brPkg::instT inst,
    input  brPkg::addrT pc,
    input  logic        pred,
    input  brPkg::dataT operandA,
    input  brPkg::dataT operandB,
    input  brPkg::tagT  tagA,
    input  brPkg::tagT  tagB,
    input  logic        aluValid,
    input  brPkg::tagT  aluTag,
    input  brPkg::dataT aluData,
    input  logic        lsValid,
    input  brPkg::tagT  lsTag,
    input  brPkg::dataT lsData,
    output logic        resolveValid,
    output brPkg::addrT resolvePc,
    output logic        resolveTaken,
    output brPkg::addrT resolveTarget,
    output logic        mispredict,
    output brPkg::addrT redirectPc
);

    logic flush;
    logic qFull;

    allocIf   allocBus ();
    wakeupIf  wakeupBus ();
    issueIf   issueBus ();
    resolveIf resolveBus ();

    assign wakeupBus.aluValid = aluValid;
    assign wakeupBus.aluTag   = aluTag;
    assign wakeupBus.aluData  = aluData;
    assign wakeupBus.lsValid  = lsValid;
    assign wakeupBus.lsTag    = lsTag;
    assign wakeupBus.lsData   = lsData;

    branchDecode decode (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .dispatchValid (dispatchValid),
        .dispatchReady (dispatchReady),
        .inst          (inst),
        .pc            (pc),
        .pred          (pred),
        .operandA      (operandA),
        .operandB      (operandB),
        .tagA          (tagA),
        .tagB          (tagB),
        .qFull         (qFull),
        .alloc         (allocBus)
    );

    branchRs rs (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .alloc  (allocBus),
        .wakeup (wakeupBus),
        .qFull  (qFull),
        .issue  (issueBus)
    );

    branchExecute execute (
        .clk     (clk),
        .rst     (rst),
        .flush   (flush),
        .issue   (issueBus),
        .resolve (resolveBus)
    );

    branchResult result (
        .clk           (clk),
        .rst           (rst),
        .resolve       (resolveBus),
        .flush         (flush),
        .resolveValid  (resolveValid),
        .resolveTaken  (resolveTaken),
        .mispredict    (mispredict),
        .resolvePc     (resolvePc),
        .resolveTarget (resolveTarget),
        .redirectPc    (redirectPc)
    );

endmodule

//--- verilog/branchDecode.sv
`timescale 1ns/1ns

module branchDecode (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        dispatchValid,
    output logic        dispatchReady,
    input  brPkg::instT inst,
    input  brPkg::addrT pc,
    input  logic        pred,
    input  brPkg::dataT operandA,
    input  brPkg::dataT operandB,
    input  brPkg::tagT  tagA,
    input  brPkg::tagT  tagB,
    input  logic        qFull,
    allocIf.source      alloc
);

    logic        started;
    logic        accept;
    brPkg::dataT immB;

    // B-type immediate, bit zero is always clear
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // started keeps dispatch closed for the first cycle after reset
    assign dispatchReady = started && !qFull && !flush;
    assign accept        = dispatchValid && dispatchReady;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started     <= 1'b0;
            alloc.valid <= 1'b0;
        end else begin
            started     <= 1'b1;
            alloc.valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            // illegal funct3 values pass through and execute as never taken
            alloc.op       <= brPkg::brOpT'(inst[14:12]);
            alloc.imm      <= immB;
            alloc.pc       <= pc;
            alloc.pred     <= pred;
            alloc.operandA <= operandA;
            alloc.operandB <= operandB;
            alloc.tagA     <= tagA;
            alloc.tagB     <= tagB;
        end
    end

endmodule

//--- verilog/branchExecute.sv
`timescale 1ns/1ns

module branchExecute (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    issueIf.sink     issue,
    resolveIf.source resolve
);

    logic        taken;
    brPkg::addrT target;

    always_comb begin
        case (issue.op)
            brPkg::opBeq:  taken = issue.operandA == issue.operandB;
            brPkg::opBne:  taken = issue.operandA != issue.operandB;
            brPkg::opBlt:  taken = $signed(issue.operandA) < $signed(issue.operandB);
            brPkg::opBge:  taken = $signed(issue.operandA) >= $signed(issue.operandB);
            brPkg::opBltu: taken = issue.operandA < issue.operandB;
            brPkg::opBgeu: taken = issue.operandA >= issue.operandB;
            // funct3 010 and 011 are not branches and never jump
            default:       taken = 1'b0;
        endcase
    end

    assign target = issue.pc + issue.imm;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resolve.valid <= 1'b0;
        end else if (flush) begin
            resolve.valid <= 1'b0;
        end else begin
            resolve.valid <= issue.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            resolve.pc     <= issue.pc;
            resolve.taken  <= taken;
            resolve.target <= target;
            resolve.pred   <= issue.pred;
        end
    end

endmodule

//--- verilog/branchResult.sv
`timescale 1ns/1ns

module branchResult (
    input  logic        clk,
    input  logic        rst,
    resolveIf.sink      resolve,
    output logic        flush,
    output logic        resolveValid,
    output logic        resolveTaken,
    output logic        mispredict,
    output brPkg::addrT resolvePc,
    output brPkg::addrT resolveTarget,
    output brPkg::addrT redirectPc
);

    logic predReg;

    // anything arriving during a flush cycle is younger than the mispredicted branch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resolveValid <= 1'b0;
        end else begin
            resolveValid <= resolve.valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        resolvePc     <= resolve.pc;
        resolveTaken  <= resolve.taken;
        resolveTarget <= resolve.target;
        predReg       <= resolve.pred;
    end

    assign mispredict = resolveValid && (resolveTaken != predReg);
    assign flush      = mispredict;
    assign redirectPc = resolveTaken ? resolveTarget : resolvePc + 32'd4;

endmodule

//--- verilog/branchRs.sv
`timescale 1ns/1ns

module branchRs (
    input  logic   clk,
    input  logic   rst,
    input  logic   flush,
    allocIf.sink   alloc,
    wakeupIf.sink  wakeup,
    output logic   qFull,
    issueIf.source issue
);

    logic [brPkg::rsSize-1:0]        lineReady;
    logic [brPkg::rsSize-1:0]        allocEn;
    brPkg::dataT                     lineOperandA [brPkg::rsSize];
    brPkg::dataT                     lineOperandB [brPkg::rsSize];
    brPkg::brOpT                     lineOp [brPkg::rsSize];
    brPkg::dataT                     lineImm [brPkg::rsSize];
    brPkg::addrT                     linePc [brPkg::rsSize];
    logic                            linePred [brPkg::rsSize];
    brPkg::slotT                     head;
    brPkg::slotT                     tail;
    logic [$clog2(brPkg::rsSize):0]  count;
    logic                            canIssue;

    for (genvar j = 0; j < brPkg::rsSize; j++) begin : gLine
        assign allocEn[j] = alloc.valid && (tail == brPkg::slotT'(j));

        branchRsLine line (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .allocEn  (allocEn[j]),
            .alloc    (alloc),
            .wakeup   (wakeup),
            .ready    (lineReady[j]),
            .operandA (lineOperandA[j]),
            .operandB (lineOperandB[j]),
            .op       (lineOp[j]),
            .imm      (lineImm[j]),
            .pc       (linePc[j]),
            .pred     (linePred[j])
        );
    end

    assign canIssue = (count != 0) && lineReady[head];

    // the branch sitting in the decode register already owns a slot
    assign qFull = (count >= brPkg::rsSize - 1) && (alloc.valid || count == brPkg::rsSize);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            issue.valid <= 1'b0;
        end else if (flush) begin
            head        <= '0;
            tail        <= '0;
            count       <= '0;
            issue.valid <= 1'b0;
        end else begin
            issue.valid <= canIssue;
            if (alloc.valid) begin
                tail <= tail + 1'b1;
            end
            if (canIssue) begin
                head <= head + 1'b1;
            end
            case ({alloc.valid, canIssue})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (canIssue) begin
            issue.op       <= lineOp[head];
            issue.operandA <= lineOperandA[head];
            issue.operandB <= lineOperandB[head];
            issue.imm      <= lineImm[head];
            issue.pc       <= linePc[head];
            issue.pred     <= linePred[head];
        end
    end

endmodule

//--- verilog/branchRsLine.sv
`timescale 1ns/1ns

module branchRsLine (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        allocEn,
    allocIf.sink        alloc,
    wakeupIf.sink       wakeup,
    output logic        ready,
    output brPkg::dataT operandA,
    output brPkg::dataT operandB,
    output brPkg::brOpT op,
    output brPkg::dataT imm,
    output brPkg::addrT pc,
    output logic        pred
);

    brPkg::tagT  tagA;
    brPkg::tagT  tagB;
    brPkg::dataT dataA;
    brPkg::dataT dataB;
    brPkg::tagT  srcTagA;
    brPkg::tagT  srcTagB;
    brPkg::dataT srcDataA;
    brPkg::dataT srcDataB;
    logic        aluHitA;
    logic        aluHitB;
    logic        lsHitA;
    logic        lsHitB;
    brPkg::tagT  nxtTagA;
    brPkg::tagT  nxtTagB;
    brPkg::dataT nxtDataA;
    brPkg::dataT nxtDataB;

    function automatic logic busMatch(input brPkg::tagT t, input logic v, input brPkg::tagT busTag);
        return v && (busTag == t) && (t != brPkg::tagFree);
    endfunction

    // a new allocation snoops the buses too, so a broadcast in the same cycle is not missed
    always_comb begin
        srcTagA  = allocEn ? alloc.tagA : tagA;
        srcTagB  = allocEn ? alloc.tagB : tagB;
        srcDataA = allocEn ? alloc.operandA : dataA;
        srcDataB = allocEn ? alloc.operandB : dataB;
        aluHitA  = busMatch(srcTagA, wakeup.aluValid, wakeup.aluTag);
        aluHitB  = busMatch(srcTagB, wakeup.aluValid, wakeup.aluTag);
        lsHitA   = busMatch(srcTagA, wakeup.lsValid, wakeup.lsTag);
        lsHitB   = busMatch(srcTagB, wakeup.lsValid, wakeup.lsTag);
    end

    assign nxtTagA  = (aluHitA || lsHitA) ? brPkg::tagFree : srcTagA;
    assign nxtTagB  = (aluHitB || lsHitB) ? brPkg::tagFree : srcTagB;
    assign nxtDataA = aluHitA ? wakeup.aluData : (lsHitA ? wakeup.lsData : srcDataA);
    assign nxtDataB = aluHitB ? wakeup.aluData : (lsHitB ? wakeup.lsData : srcDataB);

    // the forwarded values let the head issue in the cycle its last operand arrives
    assign ready    = (nxtTagA == brPkg::tagFree) && (nxtTagB == brPkg::tagFree);
    assign operandA = nxtDataA;
    assign operandB = nxtDataB;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagA <= brPkg::tagFree;
            tagB <= brPkg::tagFree;
        end else if (flush) begin
            tagA <= brPkg::tagFree;
            tagB <= brPkg::tagFree;
        end else begin
            tagA <= nxtTagA;
            tagB <= nxtTagB;
        end
    end

    always_ff @(posedge clk) begin
        dataA <= nxtDataA;
        dataB <= nxtDataB;
        if (allocEn) begin
            op   <= alloc.op;
            imm  <= alloc.imm;
            pc   <= alloc.pc;
            pred <= alloc.pred;
        end
    end

endmodule
